// File: verif/fmul_input.txt
// per vector: name index line, then a, b and expected result lines of 8 hex words
// each line runs word 0 (limbs 0..3, least significant) up to word 7
00000000 // one times one
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 // small operands
00001234 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00005678 00000000 00000000 00000000 00000000 00000000 00000000 00000000
06260060 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000002 // carry into the second word
ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 fffffffe 00000000 00000000 00000000 00000000 00000000 00000000
00000003 // two word operand
00000001 00000001 00000000 00000000 00000000 00000000 00000000 00000000
ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ffffffff ffffffff 00000000 00000000 00000000 00000000 00000000 00000000
00000004 // 2^128 squared wraps to 38
00000000 00000000 00000000 00000000 00000001 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000001 00000000 00000000 00000000
00000026 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000005 // wrap by 38 and fold by 19 together
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
00000100 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00002500 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000006 // exactly 2^255 folds to 19
00000000 00000000 00000000 00000000 00000000 00000000 00000000 40000000
00000002 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000013 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000007 // 2^256-1 times one, fold ripples through every limb
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000012 00000000 00000000 00000000 00000000 00000000 00000000 80000000
00000008 // 2^255 squared
00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000000
00000169 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000009 // p times two stays at p, no final reduction
ffffffed ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff 7fffffff
00000002 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ffffffed ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff 7fffffff

// File: fmul_top.f
logic/fmul_pkg.sv
logic/reduction_adder.sv
logic/fmul_pass.sv
logic/fmul_col_buf.sv
logic/fmul_squeeze.sv
logic/fmul_wb_regs.sv
logic/fmul_top.sv
verif/fmul_tb.sv

// File: Bender.yml
package:
  name: fmul

sources:
  - logic/fmul_pkg.sv
  - logic/reduction_adder.sv
  - logic/fmul_pass.sv
  - logic/fmul_col_buf.sv
  - logic/fmul_squeeze.sv
  - logic/fmul_wb_regs.sv
  - logic/fmul_top.sv
  - target: simulation
    files:
      - verif/fmul_tb.sv

// File: verif/fmul_tb.sv
`timescale 1ns/1ps

module fmul_tb import fmul_pkg::*; ();

	// each vector is a name index and 8 words each of a, b and the expected result
	localparam int VEC_WORDS = 25;
	localparam int MAX_VECS = 16;

	logic        clk = 1'b0;
	logic        rst;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [4:0]  adr;
	logic [31:0] dat_w;
	logic [3:0]  sel;
	logic [31:0] dat_r;
	logic        ack;

	logic [31:0] vec_mem [MAX_VECS*VEC_WORDS];
	int          cycles = 0;
	int          limit = 500;

	fmul_top dut (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.sel   (sel),
		.dat_r (dat_r),
		.ack   (ack)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// watchdog whose limit is set once the vectors are counted
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout, the DUT did not finish within %0d cycles", limit);
			$display("tests failed");
			$fatal(1);
		end
	end

	task automatic check_word(input string name, input fe_word_t exp, input fe_word_t act);
		if (act.raw !== exp.raw) begin
			$display("[FAIL] %s: expected %08h, actual %08h", name, exp.raw, act.raw);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// ack comes one cycle after the request and drops again on the next
	task automatic finish_transfer();
		@(posedge clk);
		#1;
		check_flag("bus ack one cycle after request", 1'b1, ack);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(posedge clk);
		#1;
		check_flag("bus ack released after one cycle", 1'b0, ack);
	endtask

	task automatic wb_write(input logic [4:0] a, input logic [31:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		dat_w = d;
		finish_transfer();
	endtask

	// dat_r only moves on a new access, so it is still valid here
	task automatic wb_read(input logic [4:0] a, output logic [31:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		finish_transfer();
		d = dat_r;
	endtask

	// register fill pattern in which every address bit shows up
	function automatic logic [31:0] pattern_word(input logic [4:0] a);
		return {3'b101, a, 3'b010, ~a, 8'(a * 5'd7), 8'(a) ^ 8'h5a};
	endfunction

	task automatic run_vector(input int v);
		string       tag;
		logic [31:0] rd;
		int          base;
		base = v * VEC_WORDS;
		tag = $sformatf("vec%0d", vec_mem[base]);
		for (int k = 0; k < WORDS; k++) begin
			wb_write(ADR_A + 5'(k), vec_mem[base + 1 + k]);
			wb_write(ADR_B + 5'(k), vec_mem[base + 9 + k]);
		end
		// previous operation left done standing
		if (v > 0) begin
			wb_read(ADR_STAT, rd);
			check_flag({tag, " done before start"}, 1'b1, rd[STAT_DONE]);
		end
		wb_write(ADR_CTRL, 32'h1);
		wb_read(ADR_STAT, rd);
		check_flag({tag, " busy after start"}, 1'b1, rd[STAT_BUSY]);
		check_flag({tag, " done after start"}, 1'b0, rd[STAT_DONE]);
		// writes while busy must not reach the registers
		wb_write(ADR_A, ~vec_mem[base + 1]);
		wb_write(ADR_B + 5'd3, ~vec_mem[base + 12]);
		wb_write(ADR_CTRL, 32'h1);
		wb_read(ADR_A, rd);
		check_word({tag, " a word 0 while busy"}, vec_mem[base + 1], rd);
		wb_read(ADR_B + 5'd3, rd);
		check_word({tag, " b word 3 while busy"}, vec_mem[base + 12], rd);
		// watchdog bounds this poll
		do begin
			wb_read(ADR_STAT, rd);
		end while (!rd[STAT_DONE]);
		check_flag({tag, " busy at done"}, 1'b0, rd[STAT_BUSY]);
		for (int k = 0; k < WORDS; k++) begin
			wb_read(ADR_R + 5'(k), rd);
			check_word($sformatf("%s result word %0d", tag, k), vec_mem[base + 17 + k], rd);
		end
	endtask

	initial begin
		logic [31:0] rd;
		int          nvec;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		sel = 4'hf;
		$readmemh("verif/fmul_input.txt", vec_mem);
		// unloaded entries stay unknown
		nvec = 0;
		while (nvec < MAX_VECS && !$isunknown(vec_mem[nvec * VEC_WORDS]))
			nvec++;
		if (nvec == 0) begin
			$display("no test vectors could be loaded from verif/fmul_input.txt");
			$display("tests failed");
			$fatal(1);
		end
		limit = nvec * 200 + 500;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		// idle state out of reset
		wb_read(ADR_STAT, rd);
		check_flag("reset busy", 1'b0, rd[STAT_BUSY]);
		check_flag("reset done", 1'b0, rd[STAT_DONE]);
		for (int k = 0; k < WORDS; k++) begin
			wb_read(ADR_R + 5'(k), rd);
			check_word($sformatf("reset result word %0d", k), 32'h0, rd);
		end
		// operand registers hold what was written
		for (int k = 0; k < 2 * WORDS; k++)
			wb_write(ADR_A + 5'(k), pattern_word(ADR_A + 5'(k)));
		for (int k = 0; k < 2 * WORDS; k++) begin
			wb_read(ADR_A + 5'(k), rd);
			check_word($sformatf("operand readback %0d", k), pattern_word(ADR_A + 5'(k)), rd);
		end
		// vectors run back to back with no reset in between
		for (int v = 0; v < nvec; v++)
			run_vector(v);
		$display("all tests passed");
		$finish;
	end

endmodule

// File: logic/fmul_top.sv
`timescale 1ns/1ps

module fmul_top import fmul_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [4:0]  adr,
	input  logic [31:0] dat_w,
	input  logic [3:0]  sel,
	output logic [31:0] dat_r,
	output logic        ack
);

	// sequencer to multiply pass
	logic                    pass_en;
	logic [4:0]              pass_col;
	logic [LIMBS*LIMB_W-1:0] op_a;
	logic [LIMBS*LIMB_W-1:0] op_b;

	// multiply pass to column buffer
	logic             col_valid;
	logic [COL_W-1:0] col_sum;

	// column buffer to squeeze
	logic             pop;
	logic [COL_W-1:0] pop_data;
	logic             empty;

	// squeeze back to the register file
	logic       res_we;
	logic [2:0] res_idx;
	fe_word_t   res_word;
	logic       fin;

	fmul_wb_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_w    (dat_w),
		.sel      (sel),
		.dat_r    (dat_r),
		.ack      (ack),
		.pass_en  (pass_en),
		.pass_col (pass_col),
		.op_a     (op_a),
		.op_b     (op_b),
		.res_we   (res_we),
		.res_idx  (res_idx),
		.res_word (res_word),
		.fin      (fin)
	);

	fmul_pass u_pass (
		.clk       (clk),
		.rst       (rst),
		.pass_en   (pass_en),
		.pass_col  (pass_col),
		.op_a      (op_a),
		.op_b      (op_b),
		.col_valid (col_valid),
		.col_sum   (col_sum)
	);

	fmul_col_buf u_buf (
		.clk       (clk),
		.rst       (rst),
		.push      (col_valid),
		.push_data (col_sum),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty)
	);

	fmul_squeeze u_squeeze (
		.clk      (clk),
		.rst      (rst),
		.pop      (pop),
		.pop_data (pop_data),
		.empty    (empty),
		.res_we   (res_we),
		.res_idx  (res_idx),
		.res_word (res_word),
		.fin      (fin)
	);

endmodule

// File: logic/fmul_wb_regs.sv
`timescale 1ns/1ps

module fmul_wb_regs import fmul_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cyc,
	input  logic                    stb,
	input  logic                    we,
	input  logic [4:0]              adr,
	input  logic [31:0]             dat_w,
	input  logic [3:0]              sel,
	output logic [31:0]             dat_r,
	output logic                    ack,
	output logic                    pass_en,
	output logic [4:0]              pass_col,
	output logic [LIMBS*LIMB_W-1:0] op_a,
	output logic [LIMBS*LIMB_W-1:0] op_b,
	input  logic                    res_we,
	input  logic [2:0]              res_idx,
	input  fe_word_t                res_word,
	input  logic                    fin
);

	fe_word_t    a_w [WORDS];
	fe_word_t    b_w [WORDS];
	fe_word_t    r_w [WORDS];
	logic        busy;
	logic        done;
	logic        access;
	logic        wr;
	logic        hit_a;
	logic        hit_b;
	logic        hit_r;
	logic [31:0] stat;
	logic        start;

	// a transfer is taken on the first cycle of cyc and stb
	assign access = cyc & stb & ~ack;
	// full-word writes only
	assign wr = access & we & (&sel);

	// operand and result blocks decode on the upper address bits
	assign hit_a = (adr[4:3] == ADR_A[4:3]);
	assign hit_b = (adr[4:3] == ADR_B[4:3]);
	assign hit_r = (adr[4:3] == ADR_R[4:3]);

	// start only from idle
	assign start = wr & (adr == ADR_CTRL) & dat_w[0] & ~busy;

	always_comb begin
		stat = '0;
		stat[STAT_BUSY] = busy;
		stat[STAT_DONE] = done;
	end

	// operands leave through the limb view of each word
	always_comb begin
		for (int k = 0; k < WORDS; k++) begin
			for (int n = 0; n < 4; n++) begin
				op_a[(4*k + n)*LIMB_W +: LIMB_W] = a_w[k].limbs[n];
				op_b[(4*k + n)*LIMB_W +: LIMB_W] = b_w[k].limbs[n];
			end
		end
	end

	// ack pulses for one cycle per transfer
	always_ff @(posedge clk) begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (hit_a)
				dat_r <= a_w[adr[2:0]].raw;
			else if (hit_b)
				dat_r <= b_w[adr[2:0]].raw;
			else if (hit_r)
				dat_r <= r_w[adr[2:0]].raw;
			else if (adr == ADR_STAT)
				dat_r <= stat;
			else
				dat_r <= '0;
		end
		// operands are frozen while a multiply runs
		if (wr && !busy && hit_a)
			a_w[adr[2:0]].raw <= dat_w;
		if (wr && !busy && hit_b)
			b_w[adr[2:0]].raw <= dat_w;
	end

	// results read zero until the first operation ends
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < WORDS; k++) begin
				r_w[k] <= '0;
			end
		end else if (res_we) begin
			r_w[res_idx] <= res_word;
		end
	end

	// status and the column sequencer
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			pass_en <= 1'b0;
			pass_col <= '0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				done <= 1'b0;
				pass_en <= 1'b1;
				pass_col <= '0;
			end else if (pass_en) begin
				pass_col <= pass_col + 5'd1;
				// 32 columns back to back
				if (pass_col == 5'(LIMBS - 1))
					pass_en <= 1'b0;
			end
			if (fin) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

// File: logic/fmul_squeeze.sv
`timescale 1ns/1ps

module fmul_squeeze import fmul_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	output logic             pop,
	input  logic [COL_W-1:0] pop_data,
	input  logic             empty,
	output logic             res_we,
	output logic [2:0]       res_idx,
	output fe_word_t         res_word,
	output logic             fin
);

	logic [LIMB_W-1:0]  limb [LIMBS];
	logic [CARRY_W-1:0] carry;
	logic [CARRY_W-1:0] acc;
	logic [4:0]         idx;
	// phase flags, gather is neither
	logic               fold;
	logic               wr;
	logic               last;

	// first pass drains columns as they arrive
	assign pop = ~fold & ~wr & ~empty;
	assign last = (idx == 5'(LIMBS - 1));

	// second pass re-adds the stored limbs instead of new columns
	always_comb begin
		if (fold)
			acc = carry + CARRY_W'(limb[idx]);
		else
			acc = carry + CARRY_W'(pop_data);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			idx <= '0;
			carry <= '0;
			fold <= 1'b0;
			wr <= 1'b0;
			res_we <= 1'b0;
			fin <= 1'b0;
		end else begin
			res_we <= 1'b0;
			// one cycle after the last word lands
			fin <= res_we & (res_idx == 3'(WORDS - 1));
			if (pop) begin
				idx <= idx + 5'd1;
				if (last) begin
					// bit 255 and up folds back times 19
					carry <= (acc >> (LIMB_W - 1)) * CARRY_W'(19);
					fold <= 1'b1;
				end else begin
					carry <= acc >> LIMB_W;
				end
			end else if (fold) begin
				idx <= idx + 5'd1;
				carry <= acc >> LIMB_W;
				if (last) begin
					fold <= 1'b0;
					wr <= 1'b1;
					carry <= '0;
				end
			end else if (wr) begin
				res_we <= 1'b1;
				idx <= idx + 5'd1;
				if (idx[2:0] == 3'(WORDS - 1)) begin
					wr <= 1'b0;
					idx <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		// limb 31 keeps 7 bits in the first pass
		if (pop)
			limb[idx] <= last ? {1'b0, acc[LIMB_W-2:0]} : acc[LIMB_W-1:0];
		// limb 31 takes the rest here, which stays below 256
		else if (fold)
			limb[idx] <= acc[LIMB_W-1:0];
		// pack four limbs per bus word
		if (wr) begin
			res_idx <= idx[2:0];
			for (int n = 0; n < 4; n++) begin
				res_word.limbs[n] <= limb[4*idx[2:0] + n];
			end
		end
	end

endmodule

// File: logic/fmul_col_buf.sv
`timescale 1ns/1ps

module fmul_col_buf import fmul_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [COL_W-1:0] push_data,
	input  logic             pop,
	output logic [COL_W-1:0] pop_data,
	output logic             empty
);

	logic [COL_W-1:0] mem [LIMBS];
	logic [4:0]       wr_ptr;
	logic [4:0]       rd_ptr;
	logic [5:0]       count;
	logic             do_pop;

	assign empty = (count == '0);
	// a pop on an empty buffer is ignored
	assign do_pop = pop & ~empty;

	// head entry is visible without a read cycle
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// pointers wrap naturally at 32 entries
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 5'd1;
			if (do_pop)
				rd_ptr <= rd_ptr + 5'd1;
			// occupancy only moves when exactly one side is active
			if (push && !do_pop)
				count <= count + 6'd1;
			else if (!push && do_pop)
				count <= count - 6'd1;
		end
	end

endmodule

// File: logic/fmul_pass.sv
`timescale 1ns/1ps

module fmul_pass import fmul_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      pass_en,
	input  logic [4:0]                pass_col,
	input  logic [LIMBS*LIMB_W-1:0]   op_a,
	input  logic [LIMBS*LIMB_W-1:0]   op_b,
	output logic                      col_valid,
	output logic [COL_W-1:0]          col_sum
);

	// stage 1, b limb selection
	logic              en_s1;
	logic [4:0]        col_s1;
	logic [LIMB_W-1:0] b_mux [LIMBS];

	// stage 2, limb products
	logic                en_s2;
	logic [LIMBS-1:0]    do38;
	logic [2*LIMB_W-1:0] prod [LIMBS];

	// stage 3, wrap terms scaled by 38
	logic                   en_s3;
	logic [LIMBS*COL_W-1:0] term;

	// adder tree links
	logic                   en_s4;
	logic [8*COL_W-1:0]     sum_s4;
	logic                   en_s5;
	logic [2*COL_W-1:0]     sum_s5;

	// valid pipe
	always_ff @(posedge clk) begin
		if (rst) begin
			en_s1 <= 1'b0;
			en_s2 <= 1'b0;
			en_s3 <= 1'b0;
		end else begin
			en_s1 <= pass_en;
			en_s2 <= en_s1;
			en_s3 <= en_s2;
		end
	end

	always_ff @(posedge clk) begin
		// b index is (i - j) mod 32, which covers both the direct and the wrapped half
		if (pass_en) begin
			col_s1 <= pass_col;
			for (int j = 0; j < LIMBS; j++) begin
				b_mux[j] <= op_b[5'(pass_col - 5'(j))*LIMB_W +: LIMB_W];
			end
		end
		// operand a is held steady by the bus slave while busy
		if (en_s1) begin
			for (int j = 0; j < LIMBS; j++) begin
				prod[j] <= op_a[j*LIMB_W +: LIMB_W] * b_mux[j];
				do38[j] <= (j > int'(col_s1));
			end
		end
		// terms above 2^256 come back in times 38 since 2^256 = 38 mod p
		if (en_s2) begin
			for (int j = 0; j < LIMBS; j++) begin
				if (do38[j])
					term[j*COL_W +: COL_W] <= COL_W'(prod[j]) * COL_W'(38);
				else
					term[j*COL_W +: COL_W] <= COL_W'(prod[j]);
			end
		end
	end

	// 32 to 8
	reduction_adder #(.IN_BLOCKS(32), .REDUCTION(4)) u_add_l1 (
		.clk        (clk),
		.rst        (rst),
		.en         (en_s3),
		.din        (term),
		.dout_valid (en_s4),
		.dout       (sum_s4)
	);

	// 8 to 2
	reduction_adder #(.IN_BLOCKS(8), .REDUCTION(4)) u_add_l2 (
		.clk        (clk),
		.rst        (rst),
		.en         (en_s4),
		.din        (sum_s4),
		.dout_valid (en_s5),
		.dout       (sum_s5)
	);

	// 2 to 1, the finished column
	reduction_adder #(.IN_BLOCKS(2), .REDUCTION(2)) u_add_l3 (
		.clk        (clk),
		.rst        (rst),
		.en         (en_s5),
		.din        (sum_s5),
		.dout_valid (col_valid),
		.dout       (col_sum)
	);

endmodule

// File: logic/reduction_adder.sv
`timescale 1ns/1ps

module reduction_adder import fmul_pkg::*; #(
	parameter int IN_BLOCKS = 32,
	parameter int REDUCTION = 4
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      en,
	input  logic [IN_BLOCKS*COL_W-1:0]                din,
	output logic                                      dout_valid,
	output logic [(IN_BLOCKS/REDUCTION)*COL_W-1:0]    dout
);

	// number of group sums produced per stage
	localparam int OUT_BLOCKS = IN_BLOCKS / REDUCTION;

	logic [COL_W-1:0] grp_sum [OUT_BLOCKS];

	// add each run of REDUCTION neighbouring words
	always_comb begin
		for (int g = 0; g < OUT_BLOCKS; g++) begin
			grp_sum[g] = '0;
			for (int r = 0; r < REDUCTION; r++) begin
				grp_sum[g] = grp_sum[g] + din[(g*REDUCTION + r)*COL_W +: COL_W];
			end
		end
	end

	// valid follows the data by one register
	always_ff @(posedge clk) begin
		if (rst) begin
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= en;
		end
	end

	// only load when a column is actually passing through
	always_ff @(posedge clk) begin
		if (en) begin
			for (int g = 0; g < OUT_BLOCKS; g++) begin
				dout[g*COL_W +: COL_W] <= grp_sum[g];
			end
		end
	end

endmodule

// File: logic/fmul_pkg.sv
package fmul_pkg;

	// field element layout, radix 2^8 little-endian
	localparam int LIMBS = 32;
	localparam int LIMB_W = 8;

	// one column sum of the schoolbook product, 32 terms of at most 255*255*38
	localparam int COL_W = 32;

	// squeeze accumulator, column sum plus incoming carry
	localparam int CARRY_W = 40;

	// bus words per field element
	localparam int WORDS = 8;

	// word addresses on the 5-bit bus
	// operand a at 0..7, operand b at 8..15, result at 24..31
	localparam logic [4:0] ADR_A = 5'd0;
	localparam logic [4:0] ADR_B = 5'd8;
	localparam logic [4:0] ADR_CTRL = 5'd16;
	localparam logic [4:0] ADR_STAT = 5'd17;
	localparam logic [4:0] ADR_R = 5'd24;

	// status word bits
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;

	// one bus word of a field element
	// limb 4k+n of the element sits in byte n of word k
	typedef union packed {
		logic [31:0] raw;
		logic [3:0][LIMB_W-1:0] limbs;
	} fe_word_t;

endpackage
